// ==== logic/hyper_bus_pkg.sv ====
// hyperbus pin level definitions: word width, command-address layout, pin bundles
package hyper_bus_pkg;

    localparam int unsigned word_width_c = 16;
    localparam int unsigned nr_cs_c      = 2;
    localparam int unsigned ca_words_c   = 3;

    typedef logic [word_width_c-1:0] hyper_word_t;

    // 48 bit command-address, first word on the pins is the top 16 bits
    typedef struct packed {
        logic        read;         // 1 = read transaction
        logic        addr_space;   // 1 = register space
        logic        burst_linear;
        logic [28:0] upper_addr;   // word address bits above the lowest three
        logic [12:0] reserved;
        logic [2:0]  lower_addr;
    } hyper_ca_t;

    typedef struct packed {
        logic [nr_cs_c-1:0] cs_n;
        logic               ck_en;
        hyper_word_t        dq;
        logic               dq_oe;
        logic [1:0]         rwds;  // write mask per byte, high = masked
        logic               rwds_oe;
    } hyper_pins_o_t;

    typedef struct packed {
        hyper_word_t dq;
        logic        rwds;
    } hyper_pins_i_t;

endpackage

// ==== logic/hyper_trans_pkg.sv ====
// transaction level types for the hyperbus phy: requests, config, data words, responses
package hyper_trans_pkg;

    localparam int unsigned burst_width_c = 12;
    localparam int unsigned addr_width_c  = 32;
    localparam int unsigned cnt_width_c   = 8;   // latency, recovery and cs timers
    localparam int unsigned fifo_depth_c  = 4;

    typedef struct packed {
        logic [addr_width_c-1:0]           addr;
        logic [hyper_bus_pkg::nr_cs_c-1:0] cs;    // one-hot
        logic                              write;
        logic                              burst_linear;
        logic                              addr_space;
        logic [burst_width_c-1:0]          burst; // words, at least 1
    } hyper_trans_t;

    typedef struct packed {
        logic [cnt_width_c-1:0] t_acc;  // initial latency, at least 2
        logic [cnt_width_c-1:0] t_rwr;  // cs high time between transactions
        logic [cnt_width_c-1:0] t_csm;  // max cs low time
    } hyper_cfg_t;

    typedef struct packed {
        hyper_bus_pkg::hyper_word_t data;
        logic [1:0]                 strb;  // 1 = byte written
    } tx_word_t;

    typedef struct packed {
        hyper_bus_pkg::hyper_word_t data;
    } rx_word_t;

    typedef struct packed {
        logic last;
        logic error;
    } hyper_resp_t;

    // read buffer entry
    typedef struct packed {
        rx_word_t    word;
        hyper_resp_t resp;
    } rx_entry_t;

endpackage

// ==== logic/hyper_ca_gen.sv ====
// command-address generator: holds the accepted transaction and serves its three CA words
`timescale 1ns/1ns

module hyper_ca_gen (
    input  logic                          clk0,
    input  logic                          rst_ni,
    input  logic                          load_i,
    input  hyper_trans_pkg::hyper_trans_t trans_i,
    input  logic [1:0]                    sel_i,
    output hyper_bus_pkg::hyper_word_t    word_o
);
    import hyper_bus_pkg::*;
    import hyper_trans_pkg::*;

    hyper_trans_t                  trans_q;
    hyper_ca_t                     ca;
    hyper_word_t [ca_words_c-1:0]  ca_words;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_q <= '0;
        end else if (load_i) begin
            trans_q <= trans_i;
        end
    end

    always_comb begin
        ca.read         = ~trans_q.write;
        ca.addr_space   = trans_q.addr_space;
        ca.burst_linear = trans_q.burst_linear;
        ca.upper_addr   = trans_q.addr[31:3];
        ca.reserved     = '0;
        ca.lower_addr   = trans_q.addr[2:0];
    end

    assign ca_words = ca;  // index ca_words_c-1 holds the top word

    always_comb begin
        if (sel_i < 2'(ca_words_c)) begin
            word_o = ca_words[2'(ca_words_c - 1) - sel_i];
        end else begin
            word_o = '0;
        end
    end

endmodule

// ==== logic/hyper_word_fifo.sv ====
// small synchronous fifo with a type parameter payload, for write and read words
`timescale 1ns/1ns

module hyper_word_fifo #(
    parameter type         T     = logic,
    parameter int unsigned depth = 4
) (
    input  logic clk0,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic push_i,
    input  T     data_i,
    output logic full_o,
    input  logic pop_i,
    output logic valid_o,
    output T     data_o
);
    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

    T                 mem_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w:0]   count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = count_q == (ptr_w + 1)'(depth);
    assign valid_o = count_q != '0;
    assign data_o  = mem_q[rd_ptr_q];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin  // drops a push of the same cycle too
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk0) begin
        if (do_push && !flush_i) mem_q[wr_ptr_q] <= data_i;
    end

endmodule

// ==== logic/hyper_phy_seq.sv ====
// hyperbus transaction sequencer: CA, latency, burst data, cs timeout, pins and responses
`timescale 1ns/1ns

module hyper_phy_seq (
    input  logic                                      clk0,
    input  logic                                      rst_ni,
    input  hyper_trans_pkg::hyper_cfg_t               cfg_i,
    input  logic                                      trans_valid_i,
    output logic                                      trans_ready_o,
    input  logic                                      write_i,
    input  logic [hyper_trans_pkg::burst_width_c-1:0] burst_i,
    input  logic [hyper_bus_pkg::nr_cs_c-1:0]         cs_i,
    output logic                                      ca_load_o,
    output logic [1:0]                                ca_sel_o,
    input  hyper_bus_pkg::hyper_word_t                ca_word_i,
    input  logic                                      tx_valid_i,
    input  hyper_trans_pkg::tx_word_t                 tx_word_i,
    output logic                                      tx_pop_o,
    output logic                                      tx_flush_o,
    output logic                                      rx_push_o,
    output hyper_trans_pkg::rx_word_t                 rx_word_o,
    output logic                                      rx_last_o,
    input  logic                                      rx_full_i,
    input  hyper_bus_pkg::hyper_pins_i_t              pins_i,
    output hyper_bus_pkg::hyper_pins_o_t              pins_o,
    output logic                                      b_valid_o,
    output hyper_trans_pkg::hyper_resp_t              b_resp_o,
    output logic                                      err_valid_o
);
    import hyper_bus_pkg::*;
    import hyper_trans_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_ca, st_lat, st_add_lat, st_wdata, st_rdata, st_err, st_recov
    } state_e;

    state_e                   state_q;
    logic [nr_cs_c-1:0]       cs_q;
    logic                     write_q;
    logic [burst_width_c-1:0] burst_cnt_q;   // words still to move
    logic [cnt_width_c-1:0]   wait_cnt_q;
    logic [cnt_width_c-1:0]   cs_tmr_q;
    logic [cnt_width_c:0]     cs_tmr_nxt;
    logic [1:0]               ca_sel_q;
    logic                     accept;
    logic                     cs_active;
    logic                     word_xfer;
    logic                     last_word;
    logic                     done;
    logic                     timeout;

    assign trans_ready_o = state_q == st_idle;
    assign accept        = trans_valid_i && trans_ready_o;
    assign ca_load_o     = accept;
    assign ca_sel_o      = ca_sel_q;
    assign cs_active     = state_q inside {st_ca, st_lat, st_add_lat, st_wdata, st_rdata};
    assign last_word     = burst_cnt_q == burst_width_c'(1);

    // data movement, read side also fills error words after a timeout
    assign tx_pop_o    = (state_q == st_wdata) && tx_valid_i;
    assign err_valid_o = (state_q == st_err) && !write_q;
    assign tx_flush_o  = (state_q == st_err) && write_q;
    assign rx_push_o   = (((state_q == st_rdata) && pins_i.rwds) || err_valid_o) && !rx_full_i;
    assign rx_word_o.data = pins_i.dq;
    assign rx_last_o   = last_word;
    assign word_xfer   = tx_pop_o || rx_push_o;
    assign done        = word_xfer && last_word;

    assign cs_tmr_nxt = {1'b0, cs_tmr_q} + 1'b1;
    assign timeout    = cs_active && (cs_tmr_nxt >= {1'b0, cfg_i.t_csm}) && !done;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= st_recov;  // one extra idle-low cycle out of reset
            cs_q        <= '0;
            write_q     <= 1'b0;
            burst_cnt_q <= '0;
            wait_cnt_q  <= '0;
            cs_tmr_q    <= '0;
            ca_sel_q    <= '0;
            b_valid_o   <= 1'b0;
            b_resp_o    <= '0;
        end else begin
            b_valid_o <= 1'b0;
            if (cs_active) cs_tmr_q <= cs_tmr_nxt[cnt_width_c-1:0];
            if (word_xfer) burst_cnt_q <= burst_cnt_q - 1'b1;

            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q     <= st_ca;
                        cs_q        <= cs_i;
                        write_q     <= write_i;
                        burst_cnt_q <= burst_i;
                        cs_tmr_q    <= '0;
                        ca_sel_q    <= '0;
                    end
                end
                st_ca: begin
                    ca_sel_q <= ca_sel_q + 1'b1;
                    if (ca_sel_q == 2'(ca_words_c - 1)) begin
                        wait_cnt_q <= cfg_i.t_acc;
                        // memory asks for double latency with rwds high
                        state_q <= pins_i.rwds ? st_add_lat : st_lat;
                    end
                end
                st_add_lat: begin
                    if (wait_cnt_q < cnt_width_c'(2)) begin
                        wait_cnt_q <= cfg_i.t_acc;
                        state_q    <= st_lat;
                    end else begin
                        wait_cnt_q <= wait_cnt_q - 1'b1;
                    end
                end
                st_lat: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (wait_cnt_q < cnt_width_c'(2)) begin
                        state_q <= write_q ? st_wdata : st_rdata;
                    end
                end
                st_wdata, st_rdata: begin
                    if (done) begin
                        state_q    <= st_recov;
                        wait_cnt_q <= cfg_i.t_rwr;
                        b_valid_o  <= write_q;
                        b_resp_o   <= '{last: 1'b1, error: 1'b0};
                    end
                end
                st_err: begin
                    if (write_q) begin
                        state_q    <= st_recov;
                        wait_cnt_q <= cfg_i.t_rwr;
                        b_valid_o  <= 1'b1;
                        b_resp_o   <= '{last: 1'b1, error: 1'b1};
                    end else if (done) begin
                        state_q    <= st_recov;
                        wait_cnt_q <= cfg_i.t_rwr;
                    end
                end
                st_recov: begin
                    if (wait_cnt_q < cnt_width_c'(2)) begin
                        state_q <= st_idle;
                    end else begin
                        wait_cnt_q <= wait_cnt_q - 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase

            if (timeout) state_q <= st_err;
        end
    end

    always_comb begin
        pins_o      = '0;
        pins_o.cs_n = ~(cs_q & {nr_cs_c{cs_active}});
        pins_o.dq   = ca_word_i;
        case (state_q)
            st_ca: begin
                pins_o.ck_en = 1'b1;
                pins_o.dq_oe = 1'b1;
            end
            st_lat, st_add_lat: pins_o.ck_en = 1'b1;
            st_wdata: begin
                pins_o.ck_en   = tx_valid_i;  // clock held on underflow
                pins_o.dq      = tx_word_i.data;
                pins_o.dq_oe   = tx_valid_i;
                pins_o.rwds    = ~tx_word_i.strb;
                pins_o.rwds_oe = 1'b1;
            end
            st_rdata: pins_o.ck_en = !rx_full_i;  // back-pressure to the memory
            default: ;
        endcase
    end

endmodule

// ==== logic/hyper_phy.sv ====
// hyperbus phy top: CA generator, write and read buffers and the sequencer
`timescale 1ns/1ns

module hyper_phy (
    input  logic                          clk0,
    input  logic                          rst_ni,
    input  hyper_trans_pkg::hyper_cfg_t   cfg_i,
    input  logic                          trans_valid_i,
    output logic                          trans_ready_o,
    input  hyper_trans_pkg::hyper_trans_t trans_i,
    input  logic                          tx_valid_i,
    output logic                          tx_ready_o,
    input  hyper_trans_pkg::tx_word_t     tx_i,
    output logic                          rx_valid_o,
    input  logic                          rx_ready_i,
    output hyper_trans_pkg::rx_word_t     rx_o,
    output hyper_trans_pkg::hyper_resp_t  rx_resp_o,
    output logic                          b_valid_o,
    output hyper_trans_pkg::hyper_resp_t  b_resp_o,
    output hyper_bus_pkg::hyper_pins_o_t  pins_o,
    input  hyper_bus_pkg::hyper_pins_i_t  pins_i
);
    import hyper_bus_pkg::*;
    import hyper_trans_pkg::*;

    hyper_word_t ca_word;
    logic [1:0]  ca_sel;
    logic        ca_load;
    logic        tx_full;
    logic        tx_avail;
    logic        tx_pop;
    logic        tx_flush;
    tx_word_t    tx_head;
    logic        rx_push;
    logic        rx_last;
    logic        rx_full;
    logic        err_valid;
    rx_word_t    rx_word;
    rx_entry_t   rx_in;
    rx_entry_t   rx_head;

    assign tx_ready_o = !tx_full;

    // error words carry zero data
    always_comb begin
        rx_in.word.data  = err_valid ? '0 : rx_word.data;
        rx_in.resp.last  = rx_last;
        rx_in.resp.error = err_valid;
    end

    assign rx_o      = rx_head.word;
    assign rx_resp_o = rx_head.resp;

    hyper_ca_gen u_ca_gen (
        .clk0   (clk0),
        .rst_ni (rst_ni),
        .load_i (ca_load),
        .trans_i(trans_i),
        .sel_i  (ca_sel),
        .word_o (ca_word)
    );

    hyper_word_fifo #(.T(tx_word_t), .depth(fifo_depth_c)) u_tx_fifo (
        .clk0   (clk0),
        .rst_ni (rst_ni),
        .flush_i(tx_flush),
        .push_i (tx_valid_i),
        .data_i (tx_i),
        .full_o (tx_full),
        .pop_i  (tx_pop),
        .valid_o(tx_avail),
        .data_o (tx_head)
    );

    hyper_word_fifo #(.T(rx_entry_t), .depth(fifo_depth_c)) u_rx_fifo (
        .clk0   (clk0),
        .rst_ni (rst_ni),
        .flush_i(1'b0),
        .push_i (rx_push),
        .data_i (rx_in),
        .full_o (rx_full),
        .pop_i  (rx_ready_i),
        .valid_o(rx_valid_o),
        .data_o (rx_head)
    );

    hyper_phy_seq u_seq (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .cfg_i        (cfg_i),
        .trans_valid_i(trans_valid_i),
        .trans_ready_o(trans_ready_o),
        .write_i      (trans_i.write),
        .burst_i      (trans_i.burst),
        .cs_i         (trans_i.cs),
        .ca_load_o    (ca_load),
        .ca_sel_o     (ca_sel),
        .ca_word_i    (ca_word),
        .tx_valid_i   (tx_avail),
        .tx_word_i    (tx_head),
        .tx_pop_o     (tx_pop),
        .tx_flush_o   (tx_flush),
        .rx_push_o    (rx_push),
        .rx_word_o    (rx_word),
        .rx_last_o    (rx_last),
        .rx_full_i    (rx_full),
        .pins_i       (pins_i),
        .pins_o       (pins_o),
        .b_valid_o    (b_valid_o),
        .b_resp_o     (b_resp_o),
        .err_valid_o  (err_valid)
    );

endmodule

// ==== tb/hyper_clk_gen.sv ====
// testbench clock and reset source, 100 ns clock and reset held for four cycles
`timescale 1ns/1ns

module hyper_clk_gen (
    output logic clk0_o,
    output logic rst_n_o
);
    localparam int unsigned half_period_c = 50;
    localparam int unsigned reset_cycles_c = 4;

    initial begin
        clk0_o = 1'b0;
        forever #(half_period_c) clk0_o = ~clk0_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles_c) @(posedge clk0_o);
        @(negedge clk0_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== tb/hyper_phy_sva.sv ====
// pin protocol assertions for the hyperbus phy, bound into the top level
`timescale 1ns/1ns

module hyper_phy_sva (
    input logic                         clk0,
    input logic                         rst_ni,
    input hyper_bus_pkg::hyper_pins_o_t pins_o,
    input logic                         b_valid_o
);
    import hyper_bus_pkg::*;
    import hyper_trans_pkg::*;

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    a_one_cs: assert property (@(posedge clk0) disable iff (!rst_ni)
        $countones(~pins_o.cs_n) <= 1)
    else begin
        fail_cnt++;
        $error("more than one chip select low");
    end

    a_dq_oe_cs: assert property (@(posedge clk0) disable iff (!rst_ni)
        pins_o.dq_oe |-> !(&pins_o.cs_n))
    else begin
        fail_cnt++;
        $error("dq driven with no chip select low");
    end

    // write response is a single cycle pulse
    a_b_pulse: assert property (@(posedge clk0) disable iff (!rst_ni)
        b_valid_o |=> !b_valid_o)
    else begin
        fail_cnt++;
        $error("b_valid_o held longer than one cycle");
    end

endmodule

bind hyper_phy hyper_phy_sva u_sva (
    .clk0     (clk0),
    .rst_ni   (rst_ni),
    .pins_o   (pins_o),
    .b_valid_o(b_valid_o)
);

// ==== tb/hyper_phy_tb.sv ====
// hyperbus phy testbench with memory model, reference read, stimulus, checks and watchdog
`timescale 1ns/1ns

module hyper_phy_tb;
    import hyper_bus_pkg::*;
    import hyper_trans_pkg::*;

    localparam int unsigned t_acc_c       = 4;
    localparam int unsigned t_rwr_c       = 3;
    localparam int unsigned total_words_c = 147;  // sum of the longest bursts of all tests
    localparam int unsigned cycle_ns_c    = 100;

    logic          clk0;
    logic          rst_ni;
    hyper_cfg_t    cfg;
    logic          trans_valid;
    logic          trans_ready;
    hyper_trans_t  trans;
    logic          tx_valid;
    logic          tx_ready;
    tx_word_t      tx;
    logic          rx_valid;
    logic          rx_ready = 1'b0;
    rx_word_t      rx;
    hyper_resp_t   rx_resp;
    logic          b_valid;
    hyper_resp_t   b_resp;
    hyper_pins_o_t pins_o;
    hyper_pins_i_t pins_i = '0;

    hyper_word_t   mem [256];     // memory model contents
    hyper_word_t   shadow [256];  // expected contents
    logic [31:0]   rng = 32'd22168;
    logic [31:0]   rdy_rng = 32'd22168 ^ 32'h1f2e3d4c;
    int unsigned   errors = 0;
    int unsigned   n_tests = 0;
    int unsigned   n_failed = 0;
    int unsigned   b_cnt = 0;
    hyper_resp_t   b_last;
    bit            bp_mode = 1'b0;
    bit            dbl_lat = 1'b0;
    int unsigned   rd_addr;
    int unsigned   rd_len = 0;
    int unsigned   rd_cnt = 0;
    int unsigned   rd_err = 0;
    int unsigned   rd_good = 0;  // words read before the cs limit
    int unsigned   cycle = 0;
    int unsigned   ca_cycle;
    int unsigned   wr_cycle;
    int unsigned   ca_cnt = 0;
    int unsigned   lat;
    int unsigned   idx;
    int unsigned   maddr;
    logic [47:0]   ca_bits;
    hyper_ca_t     seen_ca;

    hyper_clk_gen u_clk_gen (.clk0_o(clk0), .rst_n_o(rst_ni));

    hyper_phy u_hyper_phy (
        .clk0(clk0), .rst_ni(rst_ni), .cfg_i(cfg),
        .trans_valid_i(trans_valid), .trans_ready_o(trans_ready), .trans_i(trans),
        .tx_valid_i(tx_valid), .tx_ready_o(tx_ready), .tx_i(tx),
        .rx_valid_o(rx_valid), .rx_ready_i(rx_ready), .rx_o(rx), .rx_resp_o(rx_resp),
        .b_valid_o(b_valid), .b_resp_o(b_resp), .pins_o(pins_o), .pins_i(pins_i)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int unsigned next_rand(input int unsigned n);
        rng = xorshift(rng);
        return rng % n;
    endfunction

    function automatic hyper_word_t fill_word(input int unsigned a);
        return 16'(a * 40503) ^ 16'h5a5a ^ 16'(a << 9);
    endfunction

    // expected read data from the shadow copy
    function automatic rx_word_t ref_read(input int unsigned a);
        rx_word_t w;
        w.data = shadow[a % 256];
        return w;
    endfunction

    function automatic hyper_ca_t ca_of(input hyper_trans_t t);
        hyper_ca_t c;
        c.read         = !t.write;
        c.addr_space   = t.addr_space;
        c.burst_linear = t.burst_linear;
        c.upper_addr   = t.addr[31:3];
        c.reserved     = '0;
        c.lower_addr   = t.addr[2:0];
        return c;
    endfunction

    task automatic check_rx(input rx_word_t got, input rx_word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s %h expected %h", $time, what, got.data, exp.data);
        end
    endtask

    task automatic check_resp(input hyper_resp_t got, input hyper_resp_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s last/error %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ca(input hyper_ca_t got, input hyper_ca_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("Fail %0t ns: %s %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // memory model sampling the pins before each rising edge
    always @(negedge clk0) begin
        cycle++;
        if (&pins_o.cs_n) begin
            ca_cnt = 0;
            idx    = 0;
            pins_i = '0;
        end else if (ca_cnt < ca_words_c) begin
            if (ca_cnt == 0) ca_cycle = cycle;
            ca_bits     = {ca_bits[31:0], pins_o.dq};
            pins_i.rwds = dbl_lat;  // asks for double latency
            ca_cnt++;
            if (ca_cnt == ca_words_c) begin
                seen_ca = ca_bits;
                maddr   = {seen_ca.upper_addr, seen_ca.lower_addr};
                lat     = dbl_lat ? 2 * cfg.t_acc : cfg.t_acc;
            end
        end else if (lat > 0) begin
            pins_i.rwds = 1'b0;
            if (pins_o.ck_en) lat--;
        end else if (!seen_ca.read) begin
            if (pins_o.dq_oe) begin
                if (idx == 0) wr_cycle = cycle;
                if (!pins_o.rwds[0]) mem[(maddr + idx) % 256][7:0] = pins_o.dq[7:0];
                if (!pins_o.rwds[1]) mem[(maddr + idx) % 256][15:8] = pins_o.dq[15:8];
                idx++;
            end else if (pins_o.ck_en) begin
                errors++;
                $display("ck_en high on a write gap with no word at %0t ns", $time);
            end
        end else begin
            pins_i.rwds = pins_o.ck_en;
            pins_i.dq   = mem[(maddr + idx) % 256];
            if (pins_o.ck_en) idx++;
        end
    end

    // response collection and read word comparison
    always @(negedge clk0) begin
        rx_word_t    exp_word;
        hyper_resp_t exp_resp;
        if (b_valid) begin
            b_cnt++;
            b_last = b_resp;
        end
        rdy_rng  = xorshift(rdy_rng);
        rx_ready = !bp_mode || rdy_rng[9];
        if (rx_valid && rx_ready) begin
            if (rd_cnt >= rd_len) begin
                errors++;
                $display("read word arrived after the burst had ended at %0t ns", $time);
            end else begin
                exp_resp.last  = rd_cnt == rd_len - 1;
                exp_resp.error = rd_cnt >= rd_good;
                exp_word       = exp_resp.error ? rx_word_t'('0) : ref_read(rd_addr + rd_cnt);
                check_rx(rx, exp_word, "read word");
                check_resp(rx_resp, exp_resp, "read response");
                if (rx_resp.error) rd_err++;
                rd_cnt++;
            end
        end
    end

    task automatic issue(input hyper_trans_t t);
        @(negedge clk0);
        trans       = t;
        trans_valid = 1'b1;
        while (!trans_ready) @(negedge clk0);
        @(negedge clk0);
        trans_valid = 1'b0;
    endtask

    task automatic send_words(input int unsigned a, input int unsigned n, input bit gaps,
                              input bit upd);
        tx_word_t    w;
        int unsigned i;
        bit          stop;
        i    = 0;
        stop = 1'b0;
        while (i < n && !stop) begin
            @(negedge clk0);
            tx_valid = 1'b0;
            if (b_valid) begin
                stop = 1'b1;  // early response ends the transaction
            end else if (tx_ready && !(gaps && next_rand(3) == 0)) begin
                w.data   = 16'(next_rand(65536));
                w.strb   = 2'(next_rand(4));
                tx       = w;
                tx_valid = 1'b1;
                if (upd && w.strb[0]) shadow[(a + i) % 256][7:0] = w.data[7:0];
                if (upd && w.strb[1]) shadow[(a + i) % 256][15:8] = w.data[15:8];
                i++;
            end
        end
        @(negedge clk0);
        tx_valid = 1'b0;
    endtask

    function automatic hyper_trans_t make_trans(input int unsigned a, input int unsigned n,
                                                input bit wr, input bit space);
        hyper_trans_t t;
        t.addr         = a;
        t.cs           = next_rand(2) ? 2'b10 : 2'b01;
        t.write        = wr;
        t.burst_linear = 1'(next_rand(2));
        t.addr_space   = space;
        t.burst        = 12'(n);
        return t;
    endfunction

    task automatic do_write(input int unsigned a, input int unsigned n, input bit gaps,
                            input bit upd, output hyper_resp_t resp);
        hyper_trans_t t;
        int unsigned  b0;
        t  = make_trans(a, n, 1'b1, 1'b0);
        b0 = b_cnt;
        fork
            issue(t);
            send_words(a, n, gaps, upd);
        join
        while (b_cnt == b0) @(negedge clk0);
        resp = b_last;
        repeat (t_rwr_c + 2) @(negedge clk0);
        check_count(int'(b_cnt - b0), 1, "write responses");
        check_ca(seen_ca, ca_of(t), "write command-address");
    endtask

    task automatic do_read(input int unsigned a, input int unsigned n, input bit space,
                           input bit allow_err);
        hyper_trans_t t;
        t       = make_trans(a, n, 1'b0, space);
        rd_addr = a;
        rd_len  = n;
        rd_cnt  = 0;
        rd_err  = 0;
        // data cycles run from 4 + t_acc up to the cs limit
        rd_good = allow_err ? 32'(cfg.t_csm) - 3 - t_acc_c : n;
        issue(t);
        while (rd_cnt < rd_len) @(negedge clk0);
        check_ca(seen_ca, ca_of(t), "read command-address");
    endtask

    task automatic end_test(input string name, input int unsigned err0);
        n_tests++;
        if (errors != err0) n_failed++;
        $display("test %0d %-24s %s", n_tests, name, (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        hyper_resp_t r;
        int unsigned e0;
        int unsigned n;
        cfg         = '{t_acc: 8'(t_acc_c), t_rwr: 8'(t_rwr_c), t_csm: 8'd255};
        trans_valid = 1'b0;
        trans       = '0;
        tx_valid    = 1'b0;
        tx          = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        @(posedge rst_ni);

        e0 = errors;
        n  = 1 + next_rand(8);
        do_write(16, n, 1'b0, 1'b1, r);
        check_resp(r, '{last: 1'b1, error: 1'b0}, "write response");
        do_read(16, n, 1'b0, 1'b0);
        end_test("write then read back", e0);

        e0 = errors;
        do_read(32'hdead_be05, 3, 1'b1, 1'b0);  // register space with high address bits
        end_test("command-address", e0);

        e0 = errors;
        do_write(64, 4, 1'b0, 1'b1, r);
        check_count(int'(wr_cycle - ca_cycle), 3 + t_acc_c, "single latency cycles");
        dbl_lat = 1'b1;
        do_write(72, 4, 1'b0, 1'b1, r);
        check_count(int'(wr_cycle - ca_cycle), 3 + 2 * t_acc_c, "double latency cycles");
        dbl_lat = 1'b0;
        end_test("latency doubling", e0);

        e0      = errors;
        bp_mode = 1'b1;
        do_read(128, 4 + next_rand(9), 1'b0, 1'b0);
        bp_mode = 1'b0;
        end_test("read back-pressure", e0);

        e0 = errors;
        do_write(160, 10, 1'b1, 1'b1, r);
        do_read(160, 10, 1'b0, 1'b0);
        end_test("write underflow", e0);

        e0 = errors;
        @(negedge clk0);
        cfg.t_csm = 8'd20;
        do_read(200, 40, 1'b0, 1'b1);
        if (rd_err == 0) begin
            errors++;
            $display("read past the chip-select limit gave no error word");
        end
        do_write(200, 40, 1'b0, 1'b0, r);  // contents there are unknown afterwards
        check_resp(r, '{last: 1'b1, error: 1'b1}, "timeout write response");
        cfg.t_csm = 8'd255;
        do_write(240, 4, 1'b0, 1'b1, r);
        check_resp(r, '{last: 1'b1, error: 1'b0}, "write response after timeout");
        do_read(240, 4, 1'b0, 1'b0);
        end_test("chip-select timeout", e0);

        errors += u_hyper_phy.u_sva.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog sized from the burst lengths of all tests
    initial begin
        #(longint'(total_words_c) * (2 * t_acc_c + t_rwr_c + 10) * cycle_ns_c);
        $display("run stopped by the watchdog, a transaction never completed");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== hyper_phy.f ====
logic/hyper_bus_pkg.sv
logic/hyper_trans_pkg.sv
logic/hyper_ca_gen.sv
logic/hyper_word_fifo.sv
logic/hyper_phy_seq.sv
logic/hyper_phy.sv
tb/hyper_clk_gen.sv
tb/hyper_phy_sva.sv
tb/hyper_phy_tb.sv

// ==== Bender.yml ====
package:
  name: hyper_phy

sources:
  - logic/hyper_bus_pkg.sv
  - logic/hyper_trans_pkg.sv
  - logic/hyper_ca_gen.sv
  - logic/hyper_word_fifo.sv
  - logic/hyper_phy_seq.sv
  - logic/hyper_phy.sv
  - target: simulation
    files:
      - tb/hyper_clk_gen.sv
      - tb/hyper_phy_sva.sv
      - tb/hyper_phy_tb.sv
